/* tb.f */
src/ising_cfg_pkg.sv
src/ising_tx_pkg.sv
src/spin_lane_if.sv
src/spin_sync.sv
src/analog_tx.sv
src/cmpt_dispatch.sv
src/spin_collector.sv
src/analog_tx_top.sv
tb/tb_analog_tx_top.sv

/* Bender.yml */
package:
  name: ising_analog_tx

sources:
  - files:
      - src/ising_cfg_pkg.sv
      - src/ising_tx_pkg.sv
      - src/spin_lane_if.sv
      - src/spin_sync.sv
      - src/analog_tx.sv
      - src/cmpt_dispatch.sv
      - src/spin_collector.sv
      - src/analog_tx_top.sv
  - target: test
    files:
      - tb/tb_analog_tx_top.sv

/* tb/tb_analog_tx_top.sv */
module tb_analog_tx_top;
    timeunit 1ns;
    timeprecision 1ps;

    import ising_cfg_pkg::*;
    import ising_tx_pkg::*;

    localparam int WAIT_LIMIT = 100;

    logic      clk_i;
    logic      rst_i;
    logic      en_i;
    logic      cfg_we_i;
    pipe_num_t cfg_pipe_num_i;
    spin_t     spin_i;
    logic      cmpt_finish_i;
    logic      out_valid_o;
    logic      out_ready_i;
    spin_t     out_spin_o;
    lane_idx_t out_lane_o;
    logic      idle_o;

    // expected results, in the order they leave the collector
    spin_t       exp_spin_q [$];
    int          exp_lane_q [$];
    int          pred_lane;
    logic [15:0] lfsr_q;
    int          checks;
    int          errors;
    int          errs_before;
    int          cycles;

    analog_tx_top DUT (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .en_i           (en_i),
        .cfg_we_i       (cfg_we_i),
        .cfg_pipe_num_i (cfg_pipe_num_i),
        .spin_i         (spin_i),
        .cmpt_finish_i  (cmpt_finish_i),
        .out_valid_o    (out_valid_o),
        .out_ready_i    (out_ready_i),
        .out_spin_o     (out_spin_o),
        .out_lane_o     (out_lane_o),
        .idle_o         (idle_o)
    );

    always #5 clk_i = ~clk_i;

    // output must hold still while the sink stalls
    hold_under_backpressure: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (en_i && out_valid_o && !out_ready_i) |=>
            (out_valid_o && $stable(out_spin_o) && $stable(out_lane_o))
    ) else begin
        errors++;
        $display("output dropped or changed under back-pressure at %0t", $time);
    end

    busy_when_valid: assert property (
        @(posedge clk_i) disable iff (rst_i)
        out_valid_o |-> !idle_o
    ) else begin
        errors++;
        $display("idle_o high while out_valid_o is high at %0t", $time);
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic next_spins(output spin_t v);
        for (int b = 0; b < NUM_SPIN; b++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v[b] = lfsr_q[0];
        end
    endtask

    task automatic check_value(input string name, input logic [NUM_SPIN-1:0] exp,
                               input logic [NUM_SPIN-1:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("FAIL %0t %s expected %0h got %0h", $time, name, exp, act);
        end
    endtask

    // consecutive finish pulses, then finish low at the next edge
    task automatic send_finish(input int count);
        spin_t s;
        for (int p = 0; p < count; p++) begin
            next_spins(s);
            @(posedge clk_i);
            cmpt_finish_i <= 1'b1;
            spin_i        <= s;
            exp_spin_q.push_back(s);
            exp_lane_q.push_back(pred_lane);
            pred_lane = (pred_lane + 1) % NUM_LANE;
        end
        @(posedge clk_i);
        cmpt_finish_i <= 1'b0;
    endtask

    // cycles from the finish edge until out_valid_o is seen
    task automatic wait_output(output int n);
        n = 0;
        @(negedge clk_i);
        while (!out_valid_o && n < WAIT_LIMIT) begin
            n++;
            @(negedge clk_i);
        end
        if (!out_valid_o) begin
            errors++;
            $display("timed out waiting for out_valid_o at %0t", $time);
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        do begin
            @(posedge clk_i);
            n++;
        end while (exp_spin_q.size() != 0 && n < WAIT_LIMIT);
        if (exp_spin_q.size() != 0) begin
            errors++;
            $display("timed out with %0d results never delivered", exp_spin_q.size());
        end
    endtask

    // one cycle of en_i low puts both round-robin pointers back on lane 0
    task automatic restart_round_robin();
        @(posedge clk_i);
        en_i <= 1'b0;
        @(posedge clk_i);
        en_i <= 1'b1;
        exp_spin_q.delete();
        exp_lane_q.delete();
        pred_lane = 0;
    endtask

    task automatic report_test(input int num, input string name);
        if (errors == errs_before) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - errs_before);
        end
        errs_before = errors;
    endtask

    // scoreboard, sampled between edges
    always @(negedge clk_i) begin
        if (!rst_i && en_i && out_valid_o && out_ready_i) begin
            if (exp_spin_q.size() == 0) begin
                errors++;
                $display("output at %0t with no result expected", $time);
            end else begin
                check_value("out_spin_o", exp_spin_q[0], out_spin_o);
                check_value("out_lane_o", exp_lane_q[0], out_lane_o);
                void'(exp_spin_q.pop_front());
                void'(exp_lane_q.pop_front());
            end
        end
    end

    initial begin
        clk_i          = 1'b0;
        rst_i          = 1'b1;
        en_i           = 1'b1;
        cfg_we_i       = 1'b0;
        cfg_pipe_num_i = '0;
        spin_i         = '0;
        cmpt_finish_i  = 1'b0;
        out_ready_i    = 1'b1;
        lfsr_q         = 16'd34655;
        pred_lane      = 0;
        checks         = 0;
        errors         = 0;
        errs_before    = 0;

        repeat (10) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        check_value("out_valid_o", 1'b0, out_valid_o);
        check_value("idle_o", 1'b1, idle_o);
        report_test(1, "reset state");

        send_finish(1);
        wait_output(cycles);
        check_value("out_valid_o latency", 6, cycles);
        wait_drain();
        report_test(2, "default depth");

        restart_round_robin();
        for (int p = 0; p < 2 * NUM_LANE; p++) begin
            send_finish(1);
            repeat (8) @(posedge clk_i);
        end
        wait_drain();
        report_test(3, "round-robin dispatch");

        @(posedge clk_i);
        cfg_we_i       <= 1'b1;
        cfg_pipe_num_i <= '0;
        @(posedge clk_i);
        cfg_we_i       <= 1'b0;
        send_finish(1);
        wait_output(cycles);
        check_value("out_valid_o latency", 3, cycles);
        wait_drain();
        report_test(4, "reconfiguration");

        // every lane fills while the sink stalls
        @(posedge clk_i);
        out_ready_i <= 1'b0;
        send_finish(NUM_LANE);
        repeat (8) @(posedge clk_i);
        out_ready_i <= 1'b1;
        wait_drain();
        @(negedge clk_i);
        check_value("idle_o", 1'b1, idle_o);
        report_test(5, "back-pressure");

        restart_round_robin();
        @(posedge clk_i);
        out_ready_i <= 1'b0;
        send_finish(2);
        wait_output(cycles);
        repeat (3) @(posedge clk_i);
        en_i <= 1'b0;
        @(posedge clk_i);
        en_i        <= 1'b1;
        out_ready_i <= 1'b1;
        exp_spin_q.delete();
        exp_lane_q.delete();
        pred_lane = 0;
        @(negedge clk_i);
        check_value("out_valid_o", 1'b0, out_valid_o);
        check_value("idle_o", 1'b1, idle_o);
        // whatever was held or in flight is gone
        repeat (20) begin
            @(negedge clk_i);
            check_value("out_valid_o", 1'b0, out_valid_o);
        end
        report_test(6, "disable");

        $display("%0d checks run, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* src/analog_tx_top.sv */
module analog_tx_top (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      en_i,
    input  logic                      cfg_we_i,
    input  ising_cfg_pkg::pipe_num_t  cfg_pipe_num_i,
    input  ising_cfg_pkg::spin_t      spin_i,
    input  logic                      cmpt_finish_i,
    output logic                      out_valid_o,
    input  logic                      out_ready_i,
    output ising_cfg_pkg::spin_t      out_spin_o,
    output ising_tx_pkg::lane_idx_t   out_lane_o,
    output logic                      idle_o
);
    import ising_cfg_pkg::*;
    import ising_tx_pkg::*;

    lane_mask_t lane_finish;

    // one bundle per lane
    spin_lane_if lane_if [NUM_LANE] ();

    cmpt_dispatch u_dispatch (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .en_i          (en_i),
        .finish_i      (cmpt_finish_i),
        .lane_finish_o (lane_finish)
    );

    // spins and config are shared, finish is per lane
    for (genvar g = 0; g < NUM_LANE; g++) begin : g_tx
        analog_tx u_tx (
            .clk_i          (clk_i),
            .rst_i          (rst_i),
            .en_i           (en_i),
            .cfg_we_i       (cfg_we_i),
            .finish_i       (lane_finish[g]),
            .cfg_pipe_num_i (cfg_pipe_num_i),
            .spin_i         (spin_i),
            .lane           (lane_if[g])
        );
    end

    spin_collector u_collector (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .en_i        (en_i),
        .lanes       (lane_if),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_spin_o  (out_spin_o),
        .out_lane_o  (out_lane_o),
        .idle_o      (idle_o)
    );

endmodule

/* src/spin_collector.sv */
module spin_collector (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      en_i,
    spin_lane_if.collector            lanes [ising_cfg_pkg::NUM_LANE],
    output logic                      out_valid_o,
    input  logic                      out_ready_i,
    output ising_cfg_pkg::spin_t      out_spin_o,
    output ising_tx_pkg::lane_idx_t   out_lane_o,
    output logic                      idle_o
);
    import ising_cfg_pkg::*;
    import ising_tx_pkg::*;

    coll_state_e state_q;
    lane_idx_t   ptr_q;
    lane_mask_t  lane_valid;
    lane_mask_t  lane_idle;
    lane_mask_t  ready_mask;
    spin_t       lane_spin [NUM_LANE];
    lane_idx_t   grant_idx;
    logic        grant_found;
    logic        take;
    spin_t       out_spin_q;
    lane_idx_t   out_lane_q;

    // flatten the interface array
    for (genvar g = 0; g < NUM_LANE; g++) begin : g_lane
        assign lane_valid[g] = lanes[g].valid;
        assign lane_idle[g]  = lanes[g].idle;
        assign lane_spin[g]  = lanes[g].spins;
        assign lanes[g].ready = ready_mask[g];
    end

    // first valid lane at or after the pointer
    always_comb begin
        lane_idx_t cand;
        grant_idx   = ptr_q;
        grant_found = 1'b0;
        // walk backwards so the nearest lane is chosen last
        for (int i = NUM_LANE - 1; i >= 0; i--) begin
            cand = ptr_q + lane_idx_t'(i);
            if (lane_valid[cand]) begin
                grant_idx   = cand;
                grant_found = 1'b1;
            end
        end
    end

    assign take       = (state_q == COLL_IDLE) & en_i & grant_found;
    assign ready_mask = take ? (lane_mask_t'(1) << grant_idx) : '0;

    always_ff @(posedge clk_i) begin
        if (rst_i || !en_i) begin
            state_q <= COLL_IDLE;
            ptr_q   <= '0;
        end else begin
            case (state_q)
                COLL_IDLE: begin
                    if (take) begin
                        state_q <= COLL_SEND;
                    end
                end
                COLL_SEND: begin
                    if (out_ready_i) begin
                        state_q <= COLL_IDLE;
                        ptr_q   <= out_lane_q + lane_idx_t'(1);
                    end
                end
                default: state_q <= COLL_IDLE;
            endcase
        end
    end

    // output payload held through back-pressure
    always_ff @(posedge clk_i) begin
        if (take) begin
            out_spin_q <= lane_spin[grant_idx];
            out_lane_q <= grant_idx;
        end
    end

    assign out_valid_o = (state_q == COLL_SEND);
    assign out_spin_o  = out_spin_q;
    assign out_lane_o  = out_lane_q;
    assign idle_o      = (state_q == COLL_IDLE) & (&lane_idle);

endmodule

/* src/cmpt_dispatch.sv */
module cmpt_dispatch (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      en_i,
    input  logic                      finish_i,
    output ising_tx_pkg::lane_mask_t  lane_finish_o
);
    import ising_cfg_pkg::*;
    import ising_tx_pkg::*;

    lane_idx_t ptr_q;
    logic      fire;

    assign fire = finish_i & en_i;

    // one-hot pulse to the lane under the pointer, same cycle
    assign lane_finish_o = fire ? (lane_mask_t'(1) << ptr_q) : '0;

    always_ff @(posedge clk_i) begin
        if (rst_i || !en_i) begin
            ptr_q <= '0;
        end else if (fire) begin
            if (ptr_q == lane_idx_t'(NUM_LANE - 1)) begin
                ptr_q <= '0;
            end else begin
                ptr_q <= ptr_q + lane_idx_t'(1);
            end
        end
    end

endmodule

/* src/analog_tx.sv */
module analog_tx (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      en_i,
    input  logic                      cfg_we_i,
    input  logic                      finish_i,
    input  ising_cfg_pkg::pipe_num_t  cfg_pipe_num_i,
    input  ising_cfg_pkg::spin_t      spin_i,
    spin_lane_if.lane                 lane
);
    import ising_cfg_pkg::*;

    pipe_num_t pipe_num_q;
    logic      sync_valid;
    spin_t     sync_spin;
    logic      valid_q;
    spin_t     spin_q;
    logic      handshake;
    logic      set_valid;

    // depth register, deepest setting out of reset
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pipe_num_q <= '1;
        end else if (cfg_we_i && en_i) begin
            pipe_num_q <= cfg_pipe_num_i;
        end
    end

    spin_sync u_spin_sync (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .en_i       (en_i),
        .finish_i   (finish_i),
        .pipe_num_i (pipe_num_q),
        .spin_i     (spin_i),
        .valid_o    (sync_valid),
        .spin_o     (sync_spin)
    );

    assign handshake = valid_q & lane.ready;
    assign set_valid = sync_valid & en_i;

    // a fresh result wins over the handshake clear
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else if (set_valid) begin
            valid_q <= 1'b1;
        end else if (!en_i || handshake) begin
            valid_q <= 1'b0;
        end
    end

    // newer spins overwrite a held result
    always_ff @(posedge clk_i) begin
        if (set_valid) begin
            spin_q <= sync_spin;
        end
    end

    assign lane.valid = valid_q;
    assign lane.spins = spin_q;
    assign lane.idle  = ~valid_q;

endmodule

/* src/spin_sync.sv */
module spin_sync (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      en_i,
    input  logic                      finish_i,
    input  ising_cfg_pkg::pipe_num_t  pipe_num_i,
    input  ising_cfg_pkg::spin_t      spin_i,
    output logic                      valid_o,
    output ising_cfg_pkg::spin_t      spin_o
);
    import ising_cfg_pkg::*;

    // capture stage, loaded at the finish edge
    logic  cap_vld_q;
    spin_t cap_spin_q;

    // synchronizer chain
    logic [SYNC_DEPTH-1:0] vld_q;
    spin_t                 spin_q [SYNC_DEPTH];

    always_ff @(posedge clk_i) begin
        if (rst_i || !en_i) begin
            cap_vld_q <= 1'b0;
            vld_q     <= '0;
        end else begin
            cap_vld_q <= finish_i;
            vld_q     <= {vld_q[SYNC_DEPTH-2:0], cap_vld_q};
        end
    end

    // data shifts every cycle alongside its valid bit
    always_ff @(posedge clk_i) begin
        if (finish_i) begin
            cap_spin_q <= spin_i;
        end
        spin_q[0] <= cap_spin_q;
        for (int k = 1; k < SYNC_DEPTH; k++) begin
            spin_q[k] <= spin_q[k-1];
        end
    end

    // tap at the selected depth
    assign valid_o = vld_q[pipe_num_i];
    assign spin_o  = spin_q[pipe_num_i];

endmodule

/* src/spin_lane_if.sv */
interface spin_lane_if;
    import ising_cfg_pkg::*;

    // valid is a level, held until ready is seen
    logic  valid;
    logic  ready;
    spin_t spins;
    logic  idle;

    modport lane (
        output valid,
        output spins,
        output idle,
        input  ready
    );

    modport collector (
        input  valid,
        input  spins,
        input  idle,
        output ready
    );

endinterface

/* src/ising_tx_pkg.sv */
package ising_tx_pkg;

    // bits needed to number a lane
    localparam int LANE_IDX_W = $clog2(ising_cfg_pkg::NUM_LANE);

    typedef logic [LANE_IDX_W-1:0] lane_idx_t;

    // one bit per lane
    typedef logic [ising_cfg_pkg::NUM_LANE-1:0] lane_mask_t;

    // collector FSM
    typedef enum logic {
        COLL_IDLE = 1'b0,
        COLL_SEND = 1'b1
    } coll_state_e;

endpackage

/* src/ising_cfg_pkg.sv */
package ising_cfg_pkg;

    // spin vector width from the analog macro
    localparam int NUM_SPIN = 32;

    // number of transmit lanes behind the dispatcher
    localparam int NUM_LANE = 4;

    // deepest synchronizer setting
    localparam int SYNC_DEPTH = 4;

    // width of the depth select
    localparam int PIPE_NUM_W = $clog2(SYNC_DEPTH);

    // one spin vector
    typedef logic [NUM_SPIN-1:0] spin_t;

    // selected synchronizer depth minus one
    typedef logic [PIPE_NUM_W-1:0] pipe_num_t;

endpackage
